/* Makefile */
# Verilator flow for the ML-DSA z decoder

TOP = tb_sigdecode_z

.PHONY: lint sim clean

lint:
	verilator --lint-only -sv --timing --assert --top-module $(TOP) -f tb.f

sim:
	verilator --binary -sv --timing --assert --top-module $(TOP) -Mdir obj_dir -f tb.f
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "Simulation completed successfully"

clean:
	rm -rf obj_dir

/* tb.f */
verilog/sigdecode_pkg.sv
verilog/sigdecode_z_unit.sv
verilog/z_bit_unpacker.sv
verilog/sigdecode_z_poly.sv
verilog/coef_ram.sv
verilog/sigdecode_z_wb.sv
tb/tb_sigdecode_z.sv

/* tb/tb_sigdecode_z.sv */
// Testbench for the ML-DSA z decoder

`timescale 1ns/1ps

module tb_sigdecode_z;

    logic        clk;
    logic        reset_n;
    logic        zeroize_i;
    logic        wb_cyc_i;
    logic        wb_stb_i;
    logic        wb_we_i;
    logic [sigdecode_pkg::wb_adr_width-1:0] wb_adr_i;
    logic [31:0] wb_dat_i;
    logic [31:0] wb_dat_o;
    logic        wb_ack_o;

    // Packed byte string as words and the coefficients the model expects
    logic [31:0] words [0:169];
    logic [31:0] exp_coef [0:255];
    logic [19:0] edge_z [0:4];
    logic [31:0] edge_exp [0:4];

    integer seed;
    int     errors;
    int     errors_at_start;
    int     tests_run;
    int     tests_failed;
    int     p;

    sigdecode_z_wb i_dut (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .wb_cyc_i  (wb_cyc_i),
        .wb_stb_i  (wb_stb_i),
        .wb_we_i   (wb_we_i),
        .wb_adr_i  (wb_adr_i),
        .wb_dat_i  (wb_dat_i),
        .wb_dat_o  (wb_dat_o),
        .wb_ack_o  (wb_ack_o)
    );

    always #5 clk = ~clk;

    // --------------------------------------------------
    // Wishbone master
    // --------------------------------------------------

    // One classic cycle held until ack with inputs changing 1 ns after the edge
    task automatic wb_transfer(input logic we, input logic [8:0] adr,
                               input logic [31:0] wdata, output logic [31:0] rdata);
        int cycles;
        cycles = 0;
        @(posedge clk);
        #1;
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wb_we_i  = we;
        wb_adr_i = adr;
        wb_dat_i = wdata;
        while (!wb_ack_o && (cycles < 100)) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (!wb_ack_o) begin
            $display("Wishbone request to address %h was never acknowledged", adr);
            $display("Simulation failed");
            $finish;
        end else begin
            rdata    = wb_dat_o;
            wb_cyc_i = 1'b0;
            wb_stb_i = 1'b0;
            wb_we_i  = 1'b0;
        end
    endtask

    task automatic write_word(input logic [8:0] adr, input logic [31:0] data);
        logic [31:0] unused;
        wb_transfer(1'b1, adr, data, unused);
    endtask

    task automatic clear_decoder;
        write_word(sigdecode_pkg::adr_ctrl, 32'h1);
    endtask

    task automatic send_words(input int first, input int last);
        int i;
        for (i = first; i < last; i++) begin
            write_word(sigdecode_pkg::adr_data, words[i[7:0]]);
        end
    endtask

    task automatic pulse_zeroize;
        @(posedge clk);
        #1;
        zeroize_i = 1'b1;
        @(posedge clk);
        #1;
        zeroize_i = 1'b0;
    endtask

    // --------------------------------------------------
    // Reference model
    // --------------------------------------------------

    // Coefficient is gamma1 minus z lifted into 0..q-1 when negative
    function automatic logic [31:0] decode_model(input logic [19:0] z);
        int v;
        v = (1 << sigdecode_pkg::gamma1_log2) - int'(z);
        if (v < 0) begin
            v = v + int'(sigdecode_pkg::mldsa_q);
        end
        return 32'(v);
    endfunction

    task automatic fill_random(input int n);
        int i;
        for (i = 0; i < n; i++) begin
            words[i[7:0]] = $random(seed);
        end
    endtask

    // Field k takes bits 20k to 20k+19 of the little-endian stream
    task automatic build_model;
        logic [19:0] z;
        logic [12:0] pos;
        int k;
        int b;
        for (k = 0; k < 256; k++) begin
            for (b = 0; b < 20; b++) begin
                pos = 13'(20 * k + b);
                z[b[4:0]] = words[pos[12:5]][pos[4:0]];
            end
            exp_coef[k[7:0]] = decode_model(z);
        end
    endtask

    // Edge fields cycle through the table with fixed expected results
    task automatic fill_edge;
        logic [12:0] pos;
        logic [2:0]  e;
        int k;
        int b;
        e = 3'd0;
        for (k = 0; k < 170; k++) begin
            words[k[7:0]] = 32'h0;
        end
        for (k = 0; k < 256; k++) begin
            for (b = 0; b < 20; b++) begin
                pos = 13'(20 * k + b);
                words[pos[12:5]][pos[4:0]] = edge_z[e][b[4:0]];
            end
            exp_coef[k[7:0]] = edge_exp[e];
            e = (e == 3'd4) ? 3'd0 : e + 3'd1;
        end
    endtask

    // --------------------------------------------------
    // Checks
    // --------------------------------------------------

    task automatic check_status(input logic exp_done);
        logic [31:0] got;
        logic [31:0] exp;
        exp = {30'b0, 1'b1, exp_done};
        wb_transfer(1'b0, sigdecode_pkg::adr_ctrl, 32'h0, got);
        if (got !== exp) begin
            $display("MISMATCH at %0t ns: status read %h, expected %h", $time, got, exp);
            errors++;
        end
    endtask

    task automatic compare_coefs;
        logic [31:0] got;
        int k;
        for (k = 0; k < 256; k++) begin
            wb_transfer(1'b0, sigdecode_pkg::adr_coef_base | {1'b0, k[7:0]}, 32'h0, got);
            if (got !== exp_coef[k[7:0]]) begin
                $display("MISMATCH at %0t ns: coefficient %0d read %h, expected %h",
                         $time, k, got, exp_coef[k[7:0]]);
                errors++;
            end
        end
    endtask

    task automatic begin_test;
        errors_at_start = errors;
        tests_run++;
    endtask

    task automatic end_test(input string name);
        if (errors == errors_at_start) begin
            $display("Test %0d %s: PASS", tests_run, name);
        end else begin
            tests_failed++;
            $display("Test %0d %s: FAIL", tests_run, name);
        end
    endtask

    // --------------------------------------------------
    // Test sequence
    // --------------------------------------------------

    initial begin
        clk = 1'b0;
        reset_n = 1'b0;
        zeroize_i = 1'b0;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i = 1'b0;
        wb_adr_i = 9'h0;
        wb_dat_i = 32'h0;
        seed = 32'h166ed16e;
        errors = 0;
        errors_at_start = 0;
        tests_run = 0;
        tests_failed = 0;
        // 0, 2^19, 2^19-1, 2^19+1 and 2^20-1
        edge_z[0] = 20'h00000;
        edge_z[1] = 20'h80000;
        edge_z[2] = 20'h7ffff;
        edge_z[3] = 20'h80001;
        edge_z[4] = 20'hfffff;
        edge_exp[0] = 32'd524288;
        edge_exp[1] = 32'd0;
        edge_exp[2] = 32'd1;
        edge_exp[3] = 32'd8380416;
        edge_exp[4] = 32'd7856130;

        repeat (8) @(posedge clk);
        #1;
        reset_n = 1'b1;

        begin_test;
        check_status(1'b0);
        end_test("status after reset");

        begin_test;
        for (p = 0; p < 3; p++) begin
            fill_random(sigdecode_pkg::words_per_poly);
            build_model;
            clear_decoder;
            send_words(0, sigdecode_pkg::words_per_poly);
            check_status(1'b1);
            compare_coefs;
        end
        end_test("three random polynomials");

        begin_test;
        fill_edge;
        clear_decoder;
        send_words(0, sigdecode_pkg::words_per_poly);
        check_status(1'b1);
        compare_coefs;
        end_test("edge field values");

        // The clear throws away 40 written pairs and 32 bits still in the buffer
        begin_test;
        clear_decoder;
        fill_random(51);
        send_words(0, 51);
        check_status(1'b0);
        clear_decoder;
        fill_random(sigdecode_pkg::words_per_poly);
        build_model;
        send_words(0, sigdecode_pkg::words_per_poly);
        check_status(1'b1);
        compare_coefs;
        end_test("clear in mid polynomial");

        begin_test;
        pulse_zeroize;
        check_status(1'b0);
        fill_random(sigdecode_pkg::words_per_poly);
        build_model;
        send_words(0, sigdecode_pkg::words_per_poly);
        check_status(1'b1);
        compare_coefs;
        end_test("zeroize then polynomial");

        // Words past the 160th must not touch the stored pairs
        begin_test;
        clear_decoder;
        fill_random(170);
        build_model;
        send_words(0, sigdecode_pkg::words_per_poly);
        check_status(1'b1);
        send_words(sigdecode_pkg::words_per_poly, 170);
        check_status(1'b1);
        compare_coefs;
        end_test("extra words after done");

        $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* verilog/coef_ram.sv */
// Coefficient pair memory

`timescale 1ns/1ps

module coef_ram (
    input  logic                      clk,
    input  logic                      we_i,
    input  logic [6:0]                waddr_i,
    input  logic [6:0]                raddr_i,
    input  sigdecode_pkg::coef_pair_t wdata_i,
    output sigdecode_pkg::coef_pair_t rdata_o
);

    // One entry per coefficient pair
    sigdecode_pkg::coef_pair_t mem [sigdecode_pkg::n_pair];

    // --------------------------------------------------
    // Write port
    // --------------------------------------------------

    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[waddr_i] <= wdata_i;
        end
    end

    // --------------------------------------------------
    // Read port
    // --------------------------------------------------

    // Registered read, data shows up the cycle after the address
    always_ff @(posedge clk) begin
        rdata_o <= mem[raddr_i];
    end

endmodule

/* verilog/sigdecode_pkg.sv */
// ML-DSA signature z decoder
// Shared constants and types

package sigdecode_pkg;

    // Arithmetic constants
    localparam logic [22:0] mldsa_q = 23'd8380417;
    localparam int gamma1_log2 = 19;
    localparam int z_width = gamma1_log2 + 1;
    localparam int coef_width = 23;

    // Polynomial geometry
    localparam int n_coef = 256;
    localparam int n_pair = n_coef / 2;
    localparam int pair_index_width = 7;
    localparam int words_per_poly = n_coef * z_width / 32;

    // --------------------------------------------------
    // Wishbone word address map
    // --------------------------------------------------
    localparam int wb_adr_width = 9;
    localparam logic [8:0] adr_data = 9'h000;
    localparam logic [8:0] adr_ctrl = 9'h001;
    localparam logic [8:0] adr_coef_base = 9'h100;

    // Two packed z fields, z0 sits in the low bits
    typedef struct packed {
        logic [z_width-1:0] z1;
        logic [z_width-1:0] z0;
    } z_pair_t;

    // Two decoded coefficients, c0 sits in the low bits
    typedef struct packed {
        logic [coef_width-1:0] c1;
        logic [coef_width-1:0] c0;
    } coef_pair_t;

endpackage

/* verilog/sigdecode_z_poly.sv */
// z polynomial decode lanes

`timescale 1ns/1ps

module sigdecode_z_poly (
    input  logic                      clk,
    input  logic                      reset_n,
    input  logic                      zeroize_i,
    input  logic                      clear_i,
    input  logic                      pair_valid_i,
    input  sigdecode_pkg::z_pair_t    pair_i,
    output logic                      ram_we_o,
    output logic [6:0]                ram_waddr_o,
    output sigdecode_pkg::coef_pair_t ram_wdata_o,
    output logic                      done_o
);

    logic        flush;
    logic        accept;
    logic        valid_q;
    logic [sigdecode_pkg::pair_index_width-1:0] index_q;
    logic        done_q;
    logic        last_write;
    logic [22:0] coef0;
    logic [22:0] coef1;

    // Zeroize and clear both return the block to idle
    assign flush = zeroize_i | clear_i;

    // --------------------------------------------------
    // Decode lanes
    // --------------------------------------------------

    // Lane 0 handles the lower coefficient of each pair
    sigdecode_z_unit i_lane0 (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (flush),
        .data_i    (pair_i.z0),
        .data_o    (coef0)
    );

    // Lane 1 handles the upper coefficient
    sigdecode_z_unit i_lane1 (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (flush),
        .data_i    (pair_i.z1),
        .data_o    (coef1)
    );

    // --------------------------------------------------
    // Write sequencing
    // --------------------------------------------------

    // The 128th pair in flight already counts as done, so later pairs drop
    assign accept = pair_valid_i && !done_o;
    assign last_write = valid_q && (index_q == 7'(sigdecode_pkg::n_pair - 1));
    assign done_o = done_q | last_write;

    always_ff @(posedge clk) begin
        if (!reset_n || flush) begin
            valid_q <= 1'b0;
            index_q <= '0;
            done_q  <= 1'b0;
        end else begin
            // Valid follows the one cycle latency of the lanes
            valid_q <= accept;
            if (valid_q) begin
                index_q <= index_q + 7'd1;
            end
            if (last_write) begin
                done_q <= 1'b1;
            end
        end
    end

    assign ram_we_o = valid_q;
    assign ram_waddr_o = index_q;
    assign ram_wdata_o = '{c1: coef1, c0: coef0};

    // Nothing may overwrite a finished polynomial
    a_no_write_after_done : assert property (
        @(posedge clk) disable iff (!reset_n)
        ram_we_o |-> !done_q
    );

endmodule

/* verilog/sigdecode_z_unit.sv */
// z coefficient arithmetic unit

`timescale 1ns/1ps

module sigdecode_z_unit (
    input  logic        clk,
    input  logic        reset_n,
    input  logic        zeroize_i,
    input  logic [19:0] data_i,
    output logic [22:0] data_o
);

    // First stage operands and sum
    logic [22:0] opa;
    logic [22:0] opb;
    logic [22:0] sum0;
    logic        carry0;

    // Registered first stage and second adder
    logic [22:0] sum0_q;
    logic        carry0_q;
    logic [22:0] sum1;

    // Constant operand is gamma1 = 2^19
    always_comb begin
        opa = '0;
        opa[sigdecode_pkg::gamma1_log2] = 1'b1;
    end

    // Subtraction by inverting z and adding a carry-in of one
    assign opb = ~{{(sigdecode_pkg::coef_width - sigdecode_pkg::z_width){1'b0}}, data_i};

    // Carry out set means gamma1 - z did not borrow
    assign {carry0, sum0} = {1'b0, opa} + {1'b0, opb} + 24'd1;

    always_ff @(posedge clk) begin
        if (!reset_n || zeroize_i) begin
            sum0_q   <= '0;
            // Cleared state stands for a non-negative zero difference
            carry0_q <= 1'b1;
        end else begin
            sum0_q   <= sum0;
            carry0_q <= carry0;
        end
    end

    // Second adder wraps a negative difference back into 0..q-1
    assign sum1 = sum0_q + sigdecode_pkg::mldsa_q;

    assign data_o = carry0_q ? sum0_q : sum1;

    // Every decoded coefficient is a proper residue mod q
    a_result_below_q : assert property (
        @(posedge clk) disable iff (!reset_n)
        $past(reset_n) |-> (data_o < sigdecode_pkg::mldsa_q)
    );

endmodule

/* verilog/sigdecode_z_wb.sv */
// ML-DSA z decoder with Wishbone slave

`timescale 1ns/1ps

module sigdecode_z_wb (
    input  logic        clk,
    input  logic        reset_n,
    input  logic        zeroize_i,
    input  logic        wb_cyc_i,
    input  logic        wb_stb_i,
    input  logic        wb_we_i,
    input  logic [8:0]  wb_adr_i,
    input  logic [31:0] wb_dat_i,
    output logic [31:0] wb_dat_o,
    output logic        wb_ack_o
);

    // Request FSM states
    typedef enum logic [1:0] {
        st_idle,
        st_push,
        st_read,
        st_ack
    } state_t;

    state_t state_q;
    state_t state_d;

    logic        req;
    logic        is_data;
    logic        is_ctrl;
    logic        is_coef;
    logic        in_push;
    logic        clear;
    logic        unpack_clear;
    logic        word_valid;
    logic        word_ready;
    logic        pair_valid;
    logic        ram_we;
    logic [6:0]  ram_waddr;
    logic [6:0]  ram_raddr;
    logic        done;
    logic        adr0_q;
    logic [31:0] rd_data_q;
    logic [31:0] status;
    logic [22:0] coef_sel;

    sigdecode_pkg::z_pair_t    pair;
    sigdecode_pkg::coef_pair_t ram_wdata;
    sigdecode_pkg::coef_pair_t ram_rdata;

    // --------------------------------------------------
    // Address decode
    // --------------------------------------------------

    assign req = wb_cyc_i && wb_stb_i;
    assign is_data = (wb_adr_i == sigdecode_pkg::adr_data);
    assign is_ctrl = (wb_adr_i == sigdecode_pkg::adr_ctrl);
    // Upper half of the map holds the 256 coefficients
    assign is_coef = (wb_adr_i >= sigdecode_pkg::adr_coef_base);

    // A data write may push from idle or while waiting on a full buffer
    assign in_push = (state_q == st_idle) || (state_q == st_push);
    assign word_valid = in_push && req && wb_we_i && is_data && word_ready;

    // Control write with bit 0 set gives a single cycle clear
    assign clear = (state_q == st_idle) && req && wb_we_i && is_ctrl && wb_dat_i[0];
    // Zeroize also flushes the buffered stream bits
    assign unpack_clear = clear | zeroize_i;

    // Pair index for the RAM comes straight from the first request cycle
    assign ram_raddr = wb_adr_i[7:1];

    // --------------------------------------------------
    // Request FSM
    // --------------------------------------------------

    always_comb begin
        state_d = state_q;
        case (state_q)
            st_idle: begin
                if (req) begin
                    if (wb_we_i && is_data) begin
                        state_d = word_ready ? st_ack : st_push;
                    end else if (!wb_we_i && is_coef) begin
                        state_d = st_read;
                    end else begin
                        state_d = st_ack;
                    end
                end
            end
            // Buffer drains within one cycle after emitting a pair
            st_push: begin
                if (word_ready) begin
                    state_d = st_ack;
                end
            end
            st_read: state_d = st_idle;
            st_ack: state_d = st_idle;
            default: state_d = st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset_n || zeroize_i) begin
            state_q <= st_idle;
        end else begin
            state_q <= state_d;
        end
    end

    // Latch the read details in the first request cycle
    assign status = {30'b0, word_ready, done};

    always_ff @(posedge clk) begin
        if ((state_q == st_idle) && req) begin
            adr0_q    <= wb_adr_i[0];
            rd_data_q <= (!wb_we_i && is_ctrl) ? status : 32'b0;
        end
    end

    // --------------------------------------------------
    // Read data and acknowledge
    // --------------------------------------------------

    // Even addresses map to c0 and odd ones to c1
    assign coef_sel = adr0_q ? ram_rdata.c1 : ram_rdata.c0;
    assign wb_dat_o = (state_q == st_read) ? {9'b0, coef_sel} : rd_data_q;
    assign wb_ack_o = (state_q == st_read) || (state_q == st_ack);

    // --------------------------------------------------
    // Datapath
    // --------------------------------------------------

    z_bit_unpacker i_unpacker (
        .clk          (clk),
        .reset_n      (reset_n),
        .clear_i      (unpack_clear),
        .word_valid_i (word_valid),
        .word_i       (wb_dat_i),
        .word_ready_o (word_ready),
        .pair_valid_o (pair_valid),
        .pair_o       (pair)
    );

    sigdecode_z_poly i_poly (
        .clk          (clk),
        .reset_n      (reset_n),
        .zeroize_i    (zeroize_i),
        .clear_i      (clear),
        .pair_valid_i (pair_valid),
        .pair_i       (pair),
        .ram_we_o     (ram_we),
        .ram_waddr_o  (ram_waddr),
        .ram_wdata_o  (ram_wdata),
        .done_o       (done)
    );

    coef_ram i_ram (
        .clk     (clk),
        .we_i    (ram_we),
        .waddr_i (ram_waddr),
        .raddr_i (ram_raddr),
        .wdata_i (ram_wdata),
        .rdata_o (ram_rdata)
    );

endmodule

/* verilog/z_bit_unpacker.sv */
// Word to z field pair unpacker

`timescale 1ns/1ps

module z_bit_unpacker (
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  clear_i,
    input  logic                  word_valid_i,
    input  logic [31:0]           word_i,
    output logic                  word_ready_o,
    output logic                  pair_valid_o,
    output sigdecode_pkg::z_pair_t pair_o
);

    // Little-endian bit buffer, bit 0 is the oldest bit of the stream
    logic [63:0] bit_buf_q;
    // Number of valid bits, 0 to 64
    logic [6:0]  count_q;

    logic        accept;
    logic        emit;
    logic [63:0] buf_shift;
    logic [6:0]  count_shift;

    // --------------------------------------------------
    // Handshake
    // --------------------------------------------------

    // A new word fits only while 32 bits or fewer are held
    assign word_ready_o = (count_q <= 7'd32);
    assign accept = word_valid_i && word_ready_o;

    // A full pair of 20-bit fields is ready in the low 40 bits
    assign emit = (count_q >= 7'd40);
    assign pair_valid_o = emit;
    assign pair_o = bit_buf_q[39:0];

    // --------------------------------------------------
    // Buffer update
    // --------------------------------------------------

    // Drop an emitted pair before any append in the same cycle
    always_comb begin
        if (emit) begin
            buf_shift   = bit_buf_q >> 40;
            count_shift = count_q - 7'd40;
        end else begin
            buf_shift   = bit_buf_q;
            count_shift = count_q;
        end
    end

    always_ff @(posedge clk) begin
        if (!reset_n || clear_i) begin
            // Clearing the bits too keeps the upper buffer zero for the OR below
            bit_buf_q <= '0;
            count_q   <= '0;
        end else if (accept) begin
            // New word lands right above the bits still waiting
            bit_buf_q <= buf_shift | ({32'b0, word_i} << count_shift);
            count_q   <= count_shift + 7'd32;
        end else begin
            bit_buf_q <= buf_shift;
            count_q   <= count_shift;
        end
    end

    // --------------------------------------------------
    // Checks
    // --------------------------------------------------

    // Word and pair sizes keep the fill bounded by the buffer size
    a_count_max : assert property (
        @(posedge clk) disable iff (!reset_n)
        count_q <= 7'd64
    );

    // Bus side must honor back-pressure
    a_no_push_when_full : assert property (
        @(posedge clk) disable iff (!reset_n)
        !(word_valid_i && !word_ready_o)
    );

endmodule
